// File: include/risc16_macros.svh
// RiSC-16 core constants
// Word width, register file geometry and reset vector

`ifndef RISC16_MACROS_SVH
`define RISC16_MACROS_SVH

// Data and address width
`define RISC16_XLEN 16

// Number of architectural registers
`define RISC16_NREG 8

// Register address width
`define RISC16_RAW 3

// Address of the first instruction fetched after reset
`define RISC16_RESET_PC 0

`endif

// File: src/risc16_pkg.sv
// RiSC-16 shared types
// Opcodes, word types and the pipeline stage payloads

`include "risc16_macros.svh"

package risc16_pkg;

    typedef logic [`RISC16_XLEN-1:0] word_t;
    typedef logic [`RISC16_RAW-1:0]  reg_addr_t;

    // Encoding taken from instruction bits [15:13]
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_ADDI = 3'd1,
        OP_NAND = 3'd2,
        OP_LUI  = 3'd3,
        OP_SW   = 3'd4,
        OP_LW   = 3'd5,
        OP_BEQ  = 3'd6,
        OP_JALR = 3'd7
    } opcode_e;

    // Decode output, consumed by execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        opcode_e   opcode;
        reg_addr_t tgt;
        reg_addr_t src1;
        reg_addr_t src2;
        word_t     imm;
    } dec_pkt_t;

    // Execute output, consumed by the memory stage
    typedef struct packed {
        logic      valid;
        opcode_e   opcode;
        reg_addr_t tgt;
        word_t     result;
        word_t     store_data;
    } exe_pkt_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t tgt;
        word_t     result;
    } wb_pkt_t;

    // Data memory request, one cycle per access
    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

// File: src/risc16_regfile.sv
// RiSC-16 register file
// Two asynchronous read ports, one write port, register 0 always zero

`timescale 1ns/100ps
`include "risc16_macros.svh"

module risc16_regfile (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  risc16_pkg::reg_addr_t i_rd_addr1,
    input  risc16_pkg::reg_addr_t i_rd_addr2,
    output risc16_pkg::word_t     o_rd_data1,
    output risc16_pkg::word_t     o_rd_data2,
    input  logic                  i_wr_en,
    input  risc16_pkg::reg_addr_t i_wr_addr,
    input  risc16_pkg::word_t     i_wr_data
);
    import risc16_pkg::*;

    word_t r_regs [0:`RISC16_NREG-1];

    // Entry 0 is never written, so it keeps its reset value
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `RISC16_NREG; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            r_regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rd_data1 = r_regs[i_rd_addr1];
    assign o_rd_data2 = r_regs[i_rd_addr2];

endmodule

// File: src/risc16_decoder.sv
// RiSC-16 instruction decoder
// Register field selection and immediate extension per opcode

`timescale 1ns/100ps
`include "risc16_macros.svh"

module risc16_decoder (
    input  risc16_pkg::word_t     i_inst,
    output risc16_pkg::opcode_e   o_opcode,
    output risc16_pkg::reg_addr_t o_tgt,
    output risc16_pkg::reg_addr_t o_src1,
    output risc16_pkg::reg_addr_t o_src2,
    output risc16_pkg::word_t     o_imm
);
    import risc16_pkg::*;

    reg_addr_t reg_a;
    reg_addr_t reg_b;
    reg_addr_t reg_c;
    word_t     simm_ext;
    word_t     limm_ext;

    // Fixed instruction fields
    assign o_opcode = opcode_e'(i_inst[15:13]);
    assign reg_a    = i_inst[12:10];
    assign reg_b    = i_inst[9:7];
    assign reg_c    = i_inst[2:0];

    // 7-bit signed immediate, and 10-bit LUI immediate in the top bits
    assign simm_ext = {{(`RISC16_XLEN-7){i_inst[6]}}, i_inst[6:0]};
    assign limm_ext = {i_inst[9:0], {(`RISC16_XLEN-10){1'b0}}};

    // Unused sources read register 0 so they never cause a hazard
    always_comb begin
        o_tgt  = reg_a;
        o_src1 = reg_b;
        o_src2 = '0;
        o_imm  = simm_ext;
        case (o_opcode)
            OP_ADD, OP_NAND: begin
                o_src2 = reg_c;
                o_imm  = '0;
            end
            OP_LUI: begin
                o_src1 = '0;
                o_imm  = limm_ext;
            end
            OP_SW, OP_BEQ: begin
                // rA is read, not written
                o_tgt  = '0;
                o_src2 = reg_a;
            end
            OP_JALR: o_imm = '0;
            default: ;
        endcase
    end

endmodule

// File: src/risc16_hazard.sv
// RiSC-16 hazard unit
// Operand forwarding for execute and load-use stall detection

`timescale 1ns/100ps

module risc16_hazard (
    input  risc16_pkg::dec_pkt_t i_dec,
    input  risc16_pkg::exe_pkt_t i_exe,
    input  risc16_pkg::word_t    i_mem_result,
    input  risc16_pkg::wb_pkt_t  i_wb,
    input  risc16_pkg::word_t    i_rf_data1,
    input  risc16_pkg::word_t    i_rf_data2,
    output risc16_pkg::word_t    o_op1,
    output risc16_pkg::word_t    o_op2,
    output logic                 o_load_stall
);
    import risc16_pkg::*;

    logic exe_is_load;

    // Youngest matching stage wins, register 0 is never forwarded
    function automatic word_t fwd_operand(input reg_addr_t src, input word_t rf_data);
        word_t value;
        value = rf_data;
        if (src != '0) begin
            if (i_exe.valid && (i_exe.tgt == src)) begin
                value = i_mem_result;
            end else if (i_wb.valid && (i_wb.tgt == src)) begin
                value = i_wb.result;
            end
        end
        return value;
    endfunction

    assign o_op1 = fwd_operand(i_dec.src1, i_rf_data1);
    assign o_op2 = fwd_operand(i_dec.src2, i_rf_data2);

    //----------------------------------------
    // Load-use
    //----------------------------------------
    assign exe_is_load = i_exe.valid && (i_exe.opcode == OP_LW) && (i_exe.tgt != '0);

    // Consumer waits one cycle and then takes the load data from writeback
    assign o_load_stall = i_dec.valid && exe_is_load &&
                          ((i_exe.tgt == i_dec.src1) || (i_exe.tgt == i_dec.src2));

endmodule

// File: src/risc16_alu.sv
// RiSC-16 execute unit
// Add or nand per opcode, plus BEQ and JALR redirect decision

`timescale 1ns/100ps

module risc16_alu (
    input  risc16_pkg::opcode_e i_opcode,
    input  risc16_pkg::word_t   i_pc,
    input  risc16_pkg::word_t   i_op1,
    input  risc16_pkg::word_t   i_op2,
    input  risc16_pkg::word_t   i_imm,
    output risc16_pkg::word_t   o_result,
    output risc16_pkg::word_t   o_store_data,
    output logic                o_redirect,
    output risc16_pkg::word_t   o_target
);
    import risc16_pkg::*;

    word_t operand_b;
    word_t pc_inc;

    assign pc_inc = i_pc + word_t'(1);

    // Register operand for ADD, NAND and BEQ, immediate otherwise
    assign operand_b = ((i_opcode == OP_ADD) || (i_opcode == OP_NAND) ||
                        (i_opcode == OP_BEQ)) ? i_op2 : i_imm;

    always_comb begin
        case (i_opcode)
            OP_NAND: o_result = ~(i_op1 & operand_b);
            OP_JALR: o_result = pc_inc;
            default: o_result = i_op1 + operand_b;
        endcase
    end

    assign o_store_data = i_op2;

    // Branch offset is relative to the next instruction
    assign o_redirect = (i_opcode == OP_JALR) || ((i_opcode == OP_BEQ) && (i_op1 == i_op2));
    assign o_target   = (i_opcode == OP_JALR) ? i_op1 : pc_inc + i_imm;

endmodule

// File: src/risc16_core.sv
// RiSC-16 five-stage pipelined core
// PC, stage registers, forwarding, stall and squash, memory port wiring

`timescale 1ns/100ps
`include "risc16_macros.svh"

module risc16_core (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    output risc16_pkg::word_t     o_pc,
    input  risc16_pkg::word_t     i_inst,
    output risc16_pkg::dmem_req_t o_dmem,
    input  risc16_pkg::word_t     i_dmem_rdata
);
    import risc16_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } fetch_reg_t;

    word_t      r_pc;
    fetch_reg_t r_fetch;
    dec_pkt_t   r_dec;
    exe_pkt_t   r_exe;
    wb_pkt_t    r_wb;

    opcode_e    dec_opcode;
    reg_addr_t  dec_tgt;
    reg_addr_t  dec_src1;
    reg_addr_t  dec_src2;
    word_t      dec_imm;
    word_t      rf_data1;
    word_t      rf_data2;
    word_t      op1;
    word_t      op2;
    logic       load_stall;
    word_t      alu_result;
    word_t      alu_store_data;
    logic       alu_redirect;
    word_t      alu_target;
    logic       redirect;
    word_t      mem_result;

    //----------------------------------------
    // Fetch
    //----------------------------------------
    assign o_pc = r_pc;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_pc    <= word_t'(`RISC16_RESET_PC);
            r_fetch <= '0;
        end else if (redirect) begin
            // Drop the instruction fetched this cycle
            r_pc          <= alu_target;
            r_fetch.valid <= 1'b0;
        end else if (!load_stall) begin
            r_pc    <= r_pc + word_t'(1);
            r_fetch <= '{valid: 1'b1, pc: r_pc, inst: i_inst};
        end
    end

    //----------------------------------------
    // Decode
    //----------------------------------------
    risc16_decoder u_decoder (
        .i_inst   (r_fetch.inst),
        .o_opcode (dec_opcode),
        .o_tgt    (dec_tgt),
        .o_src1   (dec_src1),
        .o_src2   (dec_src2),
        .o_imm    (dec_imm)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_dec <= '0;
        end else if (redirect) begin
            r_dec.valid <= 1'b0;
        end else if (!load_stall) begin
            r_dec <= '{valid: r_fetch.valid, pc: r_fetch.pc, opcode: dec_opcode,
                       tgt: dec_tgt, src1: dec_src1, src2: dec_src2, imm: dec_imm};
        end
    end

    //----------------------------------------
    // Execute
    //----------------------------------------
    // Registers are read here, writeback is covered by forwarding
    risc16_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rd_addr1 (r_dec.src1),
        .i_rd_addr2 (r_dec.src2),
        .o_rd_data1 (rf_data1),
        .o_rd_data2 (rf_data2),
        .i_wr_en    (r_wb.valid),
        .i_wr_addr  (r_wb.tgt),
        .i_wr_data  (r_wb.result)
    );

    risc16_hazard u_hazard (
        .i_dec        (r_dec),
        .i_exe        (r_exe),
        .i_mem_result (mem_result),
        .i_wb         (r_wb),
        .i_rf_data1   (rf_data1),
        .i_rf_data2   (rf_data2),
        .o_op1        (op1),
        .o_op2        (op2),
        .o_load_stall (load_stall)
    );

    risc16_alu u_alu (
        .i_opcode     (r_dec.opcode),
        .i_pc         (r_dec.pc),
        .i_op1        (op1),
        .i_op2        (op2),
        .i_imm        (r_dec.imm),
        .o_result     (alu_result),
        .o_store_data (alu_store_data),
        .o_redirect   (alu_redirect),
        .o_target     (alu_target)
    );

    // Operands are stale while stalled, so no redirect then
    assign redirect = r_dec.valid && !load_stall && alu_redirect;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_exe <= '0;
        end else if (load_stall) begin
            r_exe <= '0;
        end else begin
            r_exe <= '{valid: r_dec.valid, opcode: r_dec.opcode, tgt: r_dec.tgt,
                       result: alu_result, store_data: alu_store_data};
        end
    end

    //----------------------------------------
    // Memory and writeback
    //----------------------------------------
    always_comb begin
        o_dmem.addr  = r_exe.result;
        o_dmem.wdata = r_exe.store_data;
        o_dmem.we    = r_exe.valid && (r_exe.opcode == OP_SW);
    end

    assign mem_result = (r_exe.opcode == OP_LW) ? i_dmem_rdata : r_exe.result;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_wb <= '0;
        end else begin
            r_wb <= '{valid: r_exe.valid, tgt: r_exe.tgt, result: mem_result};
        end
    end

endmodule

// File: tests/risc16_props.sv
// RiSC-16 store stream and reset checks
// Bound to the core, compares every store with a hand-computed table

`timescale 1ns/100ps
`include "risc16_macros.svh"

module risc16_props (
    input logic                  i_clk,
    input logic                  i_rst_n,
    input risc16_pkg::word_t     i_pc,
    input risc16_pkg::dmem_req_t i_dmem
);
    import risc16_pkg::*;

    localparam int N_STORES = 12;
    localparam int MARKER_ADDR = 63;

    logic        check_failed;
    int unsigned store_idx;
    word_t       exp_addr [0:N_STORES-1];
    word_t       exp_data [0:N_STORES-1];

    function automatic void load_expected(int idx, int addr, int data);
        exp_addr[idx] = word_t'(addr);
        exp_data[idx] = word_t'(data);
    endfunction

    initial begin
        check_failed = 1'b0;
        // ALU chain results
        load_expected(0, 16, 16'h0005);
        load_expected(1, 17, 16'h0008);
        load_expected(2, 18, 16'h000D);
        load_expected(3, 19, 16'hFFF7);
        load_expected(4, 20, 16'h00C0);
        load_expected(5, 21, 16'h00B7);
        load_expected(6, 22, 16'h00B7);
        load_expected(7, 23, 16'h0000);
        // Load-use pairs
        load_expected(8, 24, 16'h000E);
        load_expected(9, 25, 16'hFFF7);
        // Not-taken BEQ, then the JALR link
        load_expected(10, 26, 16'h000D);
        load_expected(11, 27, 16'h001C);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            store_idx <= 0;
        end else if (i_dmem.we) begin
            store_idx <= store_idx + 1;
        end
    end

    //----------------------------------------
    // Assertions
    //----------------------------------------
    reset_state: assert property (@(posedge i_clk)
        !i_rst_n |-> (!i_dmem.we && (i_pc == word_t'(`RISC16_RESET_PC))))
        else begin
            check_failed = 1'b1;
            $error("CHECK FAILED at %0t: PC or write enable wrong during reset", $time);
        end

    store_match: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_dmem.we && (store_idx < N_STORES)) |->
            ((i_dmem.addr == exp_addr[store_idx]) && (i_dmem.wdata == exp_data[store_idx])))
        else begin
            check_failed = 1'b1;
            $error("CHECK FAILED at %0t: store %0d wrote %h to %h", $time, store_idx,
                   i_dmem.wdata, i_dmem.addr);
        end

    no_extra_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dmem.we |-> (store_idx < N_STORES))
        else begin
            check_failed = 1'b1;
            $error("CHECK FAILED at %0t: store beyond the expected table", $time);
        end

    // Squashed stores all target the marker
    no_marker_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dmem.we |-> (i_dmem.addr != word_t'(MARKER_ADDR)))
        else begin
            check_failed = 1'b1;
            $error("CHECK FAILED at %0t: store to a squashed marker address", $time);
        end

endmodule

bind risc16_core risc16_props u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_pc    (o_pc),
    .i_dmem  (o_dmem)
);

// File: tests/risc16_tb.sv
// RiSC-16 core testbench
// Program ROM, data RAM, store counter and timeout around the core

`timescale 1ns/100ps

module risc16_tb;
    import risc16_pkg::*;

    localparam int N_STORES = 12;
    localparam int DRAIN_CYCLES = 8;
    localparam int TIMEOUT_CYCLES = 500;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     inst;
    dmem_req_t dmem;
    word_t     dmem_rdata;
    word_t     rom [0:63];
    word_t     ram [0:255];
    int        store_count = 0;
    int        drain_count = 0;
    int        cycle_count = 0;

    function automatic word_t reg_reg_word(opcode_e op, int a, int b, int c);
        return {op, 3'(a), 3'(b), 4'b0000, 3'(c)};
    endfunction

    function automatic word_t reg_imm_word(opcode_e op, int a, int b, int imm);
        return {op, 3'(a), 3'(b), 7'(imm)};
    endfunction

    function automatic word_t upper_imm_word(opcode_e op, int a, int imm);
        return {op, 3'(a), 10'(imm)};
    endfunction

    risc16_core i_dut (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .o_pc         (pc),
        .i_inst       (inst),
        .o_dmem       (dmem),
        .i_dmem_rdata (dmem_rdata)
    );

    // Both memories answer in the same cycle
    assign inst       = rom[pc[5:0]];
    assign dmem_rdata = ram[dmem.addr[7:0]];

    always #10 clk = ~clk;

    initial begin
        logic [7:0] a;
        clk   = 1'b0;
        rst_n = 1'b0;
        // Unused slots are NOPs that carry their own address
        for (int i = 0; i < 64; i++) begin
            rom[i] = reg_imm_word(OP_ADDI, 0, 0, i);
        end
        for (int i = 0; i < 256; i++) begin
            a = 8'(i);
            ram[i] <= {a, ~a};
        end
        // Dependent ALU chain where r0 writes must vanish
        rom[0]  = reg_imm_word(OP_ADDI, 1, 0, 5);
        rom[1]  = reg_imm_word(OP_ADDI, 2, 1, 3);
        rom[2]  = reg_reg_word(OP_ADD, 3, 1, 2);
        rom[3]  = reg_reg_word(OP_NAND, 4, 3, 2);
        rom[4]  = upper_imm_word(OP_LUI, 5, 3);
        rom[5]  = reg_reg_word(OP_ADD, 6, 5, 4);
        rom[6]  = reg_imm_word(OP_ADDI, 0, 6, 1);
        rom[7]  = reg_reg_word(OP_ADD, 7, 0, 6);
        for (int i = 0; i < 8; i++) begin
            rom[8 + i] = reg_imm_word(OP_SW, i == 7 ? 0 : i + 1, 0, 16 + i);
        end
        // Load-use stalls
        rom[16] = reg_imm_word(OP_LW, 1, 0, 18);
        rom[17] = reg_imm_word(OP_ADDI, 2, 1, 1);
        rom[18] = reg_imm_word(OP_SW, 2, 0, 24);
        rom[19] = reg_imm_word(OP_LW, 3, 0, 19);
        rom[20] = reg_imm_word(OP_SW, 3, 0, 25);
        // Taken BEQ over two marker stores and a BEQ not taken
        rom[21] = reg_imm_word(OP_BEQ, 1, 1, 2);
        rom[22] = reg_imm_word(OP_SW, 1, 0, 63);
        rom[23] = reg_imm_word(OP_SW, 1, 0, 63);
        rom[24] = reg_imm_word(OP_BEQ, 1, 2, 1);
        rom[25] = reg_imm_word(OP_SW, 1, 0, 26);
        // JALR to 30 with link 28
        rom[26] = reg_imm_word(OP_ADDI, 4, 0, 30);
        rom[27] = reg_imm_word(OP_JALR, 5, 4, 0);
        rom[28] = reg_imm_word(OP_SW, 1, 0, 63);
        rom[29] = reg_imm_word(OP_SW, 1, 0, 63);
        rom[30] = reg_imm_word(OP_SW, 5, 0, 27);
        rom[31] = reg_imm_word(OP_BEQ, 0, 0, -1);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    always @(posedge clk) begin
        if (dmem.we) begin
            ram[dmem.addr[7:0]] <= dmem.wdata;
        end
    end

    //----------------------------------------
    // Store count and end of run
    //----------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (dmem.we) begin
                store_count <= store_count + 1;
            end
            // Run on until the pipeline is empty
            if (store_count == N_STORES) begin
                drain_count <= drain_count + 1;
            end
        end
        if (i_dut.u_props.check_failed) begin
            $display("Simulation FAILED");
            $fatal(1, "An assertion on the store stream or reset state failed");
        end else if (drain_count == DRAIN_CYCLES) begin
            $display("Simulation PASSED");
            $finish;
        end else if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Simulation FAILED");
            $fatal(1, "Timeout: only %0d of %0d stores seen", store_count, N_STORES);
        end
    end

endmodule

// File: tb.f
+incdir+include
src/risc16_pkg.sv
src/risc16_regfile.sv
src/risc16_decoder.sv
src/risc16_hazard.sv
src/risc16_alu.sv
src/risc16_core.sv
tests/risc16_props.sv
tests/risc16_tb.sv

// File: Makefile
# Verilator build and run for the RiSC-16 core testbench

VERILATOR ?= verilator
TOP       ?= risc16_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timing -j 0
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS RUN_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS)

clean:
	rm -rf $(BUILD_DIR)
